//--- Makefile
TOP = tb_unsat_clause_selector
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f tb.f -o sim
	./obj_dir/sim 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "test FAILED"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "test FAILED, run ended early"; exit 1; \
	else \
		echo "test PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- logic/recip_table.sv
// reciprocal memory, loaded by the host during setup and read by the decode stage
module recip_table (
    input  logic                clk,
    input  logic                we_i,
    input  sat_sel_pkg::addr_t  waddr_i,
    input  sat_sel_pkg::recip_t wdata_i,
    input  logic                re_i,
    input  sat_sel_pkg::addr_t  raddr_i,
    output sat_sel_pkg::recip_t rdata_o
);
    import sat_sel_pkg::*;

    // one entry per possible count
    // entry i holds floor(2^32 / i), entries 0 and 1 saturate to all ones
    recip_t mem [BUFFER_DEPTH];

    // write port, host side
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read port
    // registered, one cycle latency
    // read during a same-address write returns the old entry
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

    // a write to an unknown address would corrupt an arbitrary entry
    // and only show up much later as a bad index
    a_waddr_known : assert property (
        @(posedge clk) we_i |-> !$isunknown(waddr_i)
    ) else $error("recip_table write with unknown address");

endmodule

//--- logic/sat_sel_pkg.sv
// shared widths, table depth and pipeline stage structs for the unsat clause selector
package sat_sel_pkg;

    // clause buffer and reciprocal table depth
    localparam int BUFFER_DEPTH = 2048;
    // index / count width, enough for every buffer entry
    localparam int ADDR_W = 11;

    // random slice taken from the 32-bit random word
    localparam int RAND_W = 18;
    localparam int RAND_OFFSET = 10;

    // reciprocal entries are pure fractions, floor(2^32 / i)
    localparam int RECIP_W = 32;

    // full multiplier result, slice times reciprocal
    localparam int PROD_W = RAND_W + RECIP_W;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [RAND_W-1:0] rand_t;
    typedef logic [RECIP_W-1:0] recip_t;

    // decode to execute
    typedef struct packed {
        logic  valid;
        // count was zero, result forced to 0
        logic  zero;
        rand_t rand_n;
        addr_t m;
    } sel_req_t;

    // execute to result
    typedef struct packed {
        logic  valid;
        logic  zero;
        rand_t rand_n;
        addr_t m;
        // floor(N * recip / 2^32), true quotient or one short
        rand_t quotient;
    } sel_prod_t;

endpackage

//--- logic/sel_decode.sv
// decode stage that captures requests outside setup and reads the reciprocal table for them
module sel_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  setup_i,
    input  logic                  req_i,
    input  sat_sel_pkg::addr_t    unsat_count_i,
    input  logic [31:0]           random_i,
    output logic                  tbl_re_o,
    output sat_sel_pkg::addr_t    tbl_raddr_o,
    output sat_sel_pkg::sel_req_t req_o
);
    import sat_sel_pkg::*;

    logic     accept;
    logic     count_zero;
    // request as captured at the input edge
    sel_req_t cap;

    // requests during table load are dropped
    assign accept = req_i & ~setup_i;

    // only this stage looks at the count for zero
    assign count_zero = (unsat_count_i == '0);

    // capture register
    always_ff @(posedge clk) begin
        if (reset) begin
            cap.valid <= 1'b0;
        end else begin
            cap.valid <= accept;
        end
        // payload only moves on an accepted request
        if (accept) begin
            cap.zero   <= count_zero;
            cap.rand_n <= random_i[RAND_OFFSET +: RAND_W];
            cap.m      <= unsat_count_i;
        end
    end

    // table read issued from the captured count
    // data lines up with req_o one cycle later
    assign tbl_re_o    = cap.valid;
    assign tbl_raddr_o = cap.m;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_o.valid <= 1'b0;
        end else begin
            req_o.valid <= cap.valid;
        end
        if (cap.valid) begin
            req_o.zero   <= cap.zero;
            req_o.rand_n <= cap.rand_n;
            req_o.m      <= cap.m;
        end
    end

    // a request dropped in setup never shows up at the execute stage
    a_no_req_in_setup : assert property (
        @(posedge clk) disable iff (reset)
        $past(setup_i, 2) |-> !req_o.valid
    ) else $error("sel_decode accepted a request during setup");

endmodule

//--- logic/sel_execute.sv
// execute stage of the selector: multiplies N by the table reciprocal for a quotient estimate
module sel_execute (
    input  logic                   clk,
    input  logic                   reset,
    input  sat_sel_pkg::sel_req_t  req_i,
    input  sat_sel_pkg::recip_t    recip_i,
    output sat_sel_pkg::sel_prod_t prod_o
);
    import sat_sel_pkg::*;

    logic [PROD_W-1:0] product;

    // N * floor(2^32 / m), fixed point with RECIP_W fraction bits
    assign product = req_i.rand_n * recip_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_o.valid <= 1'b0;
        end else begin
            prod_o.valid <= req_i.valid;
        end
        if (req_i.valid) begin
            prod_o.zero   <= req_i.zero;
            prod_o.rand_n <= req_i.rand_n;
            prod_o.m      <= req_i.m;
            // integer part only
            // floor reciprocal makes this the true quotient or one below it
            prod_o.quotient <= product[RECIP_W +: RAND_W];
        end
    end

endmodule

//--- logic/sel_result.sv
// result stage of the selector: forms N mod m from the quotient estimate, keeps the sticky zero flag
module sel_result (
    input  logic                   clk,
    input  logic                   reset,
    input  sat_sel_pkg::sel_prod_t prod_i,
    input  logic                   clear_div_zero_i,
    output logic                   sel_valid_o,
    output sat_sel_pkg::addr_t     selected_o,
    output logic                   div_zero_o
);
    import sat_sel_pkg::*;

    rand_t m_ext;
    rand_t q_times_m;
    rand_t rem_raw;
    rand_t rem_fix;
    addr_t index_next;

    always_comb begin
        m_ext = rand_t'(prod_i.m);
        // q * m never exceeds N, so RAND_W bits are enough
        q_times_m = prod_i.quotient * m_ext;
        rem_raw   = prod_i.rand_n - q_times_m;
        // quotient one short leaves rem in [m, 2m)
        if (rem_raw >= m_ext) begin
            rem_fix = rem_raw - m_ext;
        end else begin
            rem_fix = rem_raw;
        end
        // zero count maps to index 0
        if (prod_i.zero) begin
            index_next = '0;
        end else begin
            index_next = addr_t'(rem_fix);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sel_valid_o <= 1'b0;
            selected_o  <= '0;
            div_zero_o  <= 1'b0;
        end else begin
            sel_valid_o <= prod_i.valid;
            // index holds until the next result
            if (prod_i.valid) begin
                selected_o <= index_next;
            end
            // set beats clear in the same cycle
            if (prod_i.valid && prod_i.zero) begin
                div_zero_o <= 1'b1;
            end else if (clear_div_zero_i) begin
                div_zero_o <= 1'b0;
            end
        end
    end

    // the single correction step is enough only if execute's estimate is off by at most one
    a_index_in_range : assert property (
        @(posedge clk) disable iff (reset)
        prod_i.valid && !prod_i.zero |=> selected_o < $past(prod_i.m)
    ) else $error("sel_result index not below its count");

endmodule

//--- logic/unsat_clause_selector.sv
// top of the unsat clause selector: reciprocal table plus the three-stage N mod m pipeline
module unsat_clause_selector (
    input  logic                clk,
    input  logic                reset,
    // table load
    input  logic                setup_i,
    input  sat_sel_pkg::addr_t  write_addr_i,
    input  sat_sel_pkg::recip_t mt_data_i,
    // selection
    input  logic                req_i,
    input  sat_sel_pkg::addr_t  unsat_count_i,
    input  logic [31:0]         random_i,
    input  logic                clear_div_zero_i,
    output logic                sel_valid_o,
    output sat_sel_pkg::addr_t  selected_o,
    output logic                div_zero_o
);
    import sat_sel_pkg::*;

    // decode to table
    logic      tbl_re;
    addr_t     tbl_raddr;
    // table to execute
    recip_t    tbl_rdata;
    // stage to stage
    sel_req_t  dec_req;
    sel_prod_t exe_prod;

    // host writes go straight in while setup is high
    recip_table i_recip_table (
        .clk     (clk),
        .we_i    (setup_i),
        .waddr_i (write_addr_i),
        .wdata_i (mt_data_i),
        .re_i    (tbl_re),
        .raddr_i (tbl_raddr),
        .rdata_o (tbl_rdata)
    );

    sel_decode i_sel_decode (
        .clk           (clk),
        .reset         (reset),
        .setup_i       (setup_i),
        .req_i         (req_i),
        .unsat_count_i (unsat_count_i),
        .random_i      (random_i),
        .tbl_re_o      (tbl_re),
        .tbl_raddr_o   (tbl_raddr),
        .req_o         (dec_req)
    );

    sel_execute i_sel_execute (
        .clk     (clk),
        .reset   (reset),
        .req_i   (dec_req),
        .recip_i (tbl_rdata),
        .prod_o  (exe_prod)
    );

    sel_result i_sel_result (
        .clk              (clk),
        .reset            (reset),
        .prod_i           (exe_prod),
        .clear_div_zero_i (clear_div_zero_i),
        .sel_valid_o      (sel_valid_o),
        .selected_o       (selected_o),
        .div_zero_o       (div_zero_o)
    );

endmodule

//--- tb.f
logic/sat_sel_pkg.sv
logic/recip_table.sv
logic/sel_decode.sv
logic/sel_execute.sv
logic/sel_result.sv
logic/unsat_clause_selector.sv
verification/tb_unsat_clause_selector.sv

//--- verification/tb_unsat_clause_selector.sv
// directed testbench for the unsat clause selector: loads the reciprocal table, then checks N mod m results
module tb_unsat_clause_selector;
    timeunit 1ns;
    timeprecision 1ps;
    import sat_sel_pkg::*;

    // 2048-cycle load plus roughly 600 request cycles, with a wide margin
    localparam int CYCLE_LIMIT = 12000;

    // expected result, one per accepted request
    typedef struct packed {
        addr_t index;
        logic  flag;
    } expect_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        setup_i;
    addr_t       write_addr_i;
    recip_t      mt_data_i;
    logic        req_i;
    addr_t       unsat_count_i;
    logic [31:0] random_i;
    logic        clear_div_zero_i;
    logic        sel_valid_o;
    addr_t       selected_o;
    logic        div_zero_o;

    expect_t exp_q[$];
    expect_t popped;
    integer  seed;
    // sticky flag as the host should see it
    logic    model_flag = 1'b0;
    int      cycles = 0;
    int      value_errors = 0;
    int      protocol_errors = 0;
    int      push_count = 0;
    int      pulse_count = 0;

    unsat_clause_selector i_unsat_clause_selector (
        .clk              (clk),
        .reset            (reset),
        .setup_i          (setup_i),
        .write_addr_i     (write_addr_i),
        .mt_data_i        (mt_data_i),
        .req_i            (req_i),
        .unsat_count_i    (unsat_count_i),
        .random_i         (random_i),
        .clear_div_zero_i (clear_div_zero_i),
        .sel_valid_o      (sel_valid_o),
        .selected_o       (selected_o),
        .div_zero_o       (div_zero_o)
    );

    always #10 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            value_errors++;
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    // outputs sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!reset && sel_valid_o) begin
            pulse_count++;
            if (exp_q.size() == 0) begin
                protocol_errors++;
                $display("result pulse at cycle %0d with no request pending", cycles);
            end else begin
                popped = exp_q.pop_front();
                compare_addr("selected_o", popped.index, selected_o);
                compare_flag("div_zero_o", popped.flag, div_zero_o);
            end
        end
    end

    // floor(2^32 / i), saturated to all ones where it does not fit
    function automatic recip_t recip_value(input int i);
        logic [63:0] full;
        if (i < 2) begin
            return '1;
        end
        full = (64'd1 << 32) / i;
        return recip_t'(full);
    endfunction

    function automatic addr_t expected_index(input addr_t m, input rand_t n);
        if (m == '0) begin
            return '0;
        end
        return addr_t'(int'(n) % int'(m));
    endfunction

    // drives one request slot and records what should come out
    task automatic request(input addr_t count, input logic [31:0] word);
        expect_t e;
        rand_t   n;
        n = word[RAND_OFFSET +: RAND_W];
        if (count == '0) begin
            model_flag = 1'b1;
        end
        e.index = expected_index(count, n);
        e.flag  = model_flag;
        exp_q.push_back(e);
        push_count++;
        req_i         = 1'b1;
        unsat_count_i = count;
        random_i      = word;
        @(posedge clk);
        #2;
    endtask

    task automatic stop_requests();
        req_i = 1'b0;
    endtask

    // until every pending result has been checked
    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic pulse_clear();
        clear_div_zero_i = 1'b1;
        @(posedge clk);
        #2;
        clear_div_zero_i = 1'b0;
    endtask

    task automatic check_reset_state();
        repeat (3) begin
            @(negedge clk);
            compare_flag("sel_valid_o", 1'b0, sel_valid_o);
            compare_addr("selected_o", '0, selected_o);
            compare_flag("div_zero_o", 1'b0, div_zero_o);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic load_table();
        setup_i = 1'b1;
        for (int i = 0; i < BUFFER_DEPTH; i++) begin
            write_addr_i = addr_t'(i);
            mt_data_i    = recip_value(i);
            @(posedge clk);
            #2;
        end
        setup_i = 1'b0;
    endtask

    // N at zero, at full scale and one below a multiple of m
    task automatic directed_counts();
        int          counts [6];
        int          k;
        logic [31:0] word;
        counts = '{1, 2, 3, 7, 1000, 2047};
        foreach (counts[c]) begin
            k = 262143 / counts[c];
            for (int v = 0; v < 3; v++) begin
                word = $random(seed);
                case (v)
                    0: word[RAND_OFFSET +: RAND_W] = '0;
                    1: word[RAND_OFFSET +: RAND_W] = '1;
                    default: word[RAND_OFFSET +: RAND_W] = rand_t'(k * counts[c] - 1);
                endcase
                request(addr_t'(counts[c]), word);
            end
        end
        stop_requests();
        wait_idle();
    endtask

    task automatic back_to_back();
        addr_t count;
        repeat (500) begin
            count = addr_t'(($unsigned($random(seed)) % 2047) + 1);
            request(count, $random(seed));
        end
        stop_requests();
        wait_idle();
    endtask

    task automatic div_zero_flag();
        // flag must survive the nonzero requests behind the zero one
        request('0, $random(seed));
        request(11'd5, $random(seed));
        request(11'd2047, $random(seed));
        stop_requests();
        wait_idle();
        compare_flag("div_zero_o", 1'b1, div_zero_o);
        pulse_clear();
        model_flag = 1'b0;
        compare_flag("div_zero_o", 1'b0, div_zero_o);
        request(11'd9, $random(seed));
        request('0, $random(seed));
        stop_requests();
        wait_idle();
        compare_flag("div_zero_o", 1'b1, div_zero_o);
        pulse_clear();
        model_flag = 1'b0;
        // zero result and clear land on the same edge, set wins
        request('0, $random(seed));
        stop_requests();
        repeat (2) @(posedge clk);
        #2;
        pulse_clear();
        wait_idle();
        compare_flag("div_zero_o", 1'b1, div_zero_o);
    endtask

    task automatic setup_block();
        logic [31:0] word;
        // entry 7 corrupted while requests keep arriving, all dropped
        setup_i       = 1'b1;
        req_i         = 1'b1;
        unsat_count_i = 11'd7;
        random_i      = $random(seed);
        write_addr_i  = 11'd7;
        mt_data_i     = '0;
        @(posedge clk);
        #2;
        // restored before setup ends
        mt_data_i = recip_value(7);
        random_i  = $random(seed);
        @(posedge clk);
        #2;
        setup_i = 1'b0;
        word = $random(seed);
        word[RAND_OFFSET +: RAND_W] = rand_t'(100000);
        request(11'd7, word);
        stop_requests();
        wait_idle();
    endtask

    initial begin
        seed             = 95;
        reset            = 1'b1;
        setup_i          = 1'b0;
        write_addr_i     = '0;
        mt_data_i        = '0;
        req_i            = 1'b0;
        unsat_count_i    = '0;
        random_i         = '0;
        clear_div_zero_i = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        check_reset_state();
        load_table();
        directed_counts();
        back_to_back();
        div_zero_flag();
        setup_block();
        if (exp_q.size() != 0) begin
            protocol_errors++;
            $display("%0d results never arrived", exp_q.size());
        end
        if (pulse_count != push_count) begin
            protocol_errors++;
            $display("saw %0d result pulses for %0d requests", pulse_count, push_count);
        end
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
